// File: src/rfo_macros.svh
`ifndef RFO_MACROS_SVH
`define RFO_MACROS_SVH

// phase word, signed count of 10 MHz cycles per oscillator period
`define THETA_W 9
// delay line index
`define DELAY_W 8
// entries in the iq delay line, one per index value
`define LINE_LEN 256

// gate dead time in clocks, 1.3 us at 10 MHz
`define DEAD_TIME 13
// clocks between loop update ticks
`define UPDATE_DIV 64
// first-order filter gain is 2^-LPF_SHIFT
`define LPF_SHIFT 2

// loop settings after reset
`define DELAY_U_INIT 68
`define TOL_INIT 5
`define LOCK_LOWER_INIT 16
`define LOCK_UPPER_INIT 40
`define QUAD_TAP_INIT 37

// config register map
`define CFG_ADDR_TOL 0
`define CFG_ADDR_LOWER 1
`define CFG_ADDR_UPPER 2
`define CFG_ADDR_QUAD 3

`endif

// File: src/rfo_pkg.sv
`include "rfo_macros.svh"

package rfo_pkg;

	// signed phase, as counted by the detector
	typedef logic signed [`THETA_W-1:0] theta_t;
	// unsigned phase magnitude and thresholds
	typedef logic [`THETA_W-1:0] mag_t;
	// delay line tap or index
	typedef logic [`DELAY_W-1:0] tap_t;

	// loop settings from the register block
	typedef struct packed {
		mag_t tolerance;
		mag_t lock_lower;
		mag_t lock_upper;
		tap_t quad_tap;
	} cfg_t;

	// one phase result per oscillator cycle
	typedef struct packed {
		theta_t theta;
		logic valid;
	} phase_meas_t;

	// filtered phase, tap and update tick
	typedef struct packed {
		theta_t theta_f;
		theta_t theta_s;
		tap_t delay_u;
		logic tick;
	} loop_status_t;

	// H-bridge gates, p is high side, n is low side
	typedef struct packed {
		logic ap;
		logic an;
		logic bp;
		logic bn;
	} gates_t;

endpackage

// File: src/loop_regs.sv
`timescale 1ns/100ps
`include "rfo_macros.svh"

module loop_regs
	import rfo_pkg::*;
(
	input  logic clk10MHz_inv,
	input  logic rst,
	input  logic cfg_we,
	input  logic [1:0] cfg_addr,
	input  logic [`THETA_W-1:0] cfg_wdata,
	output cfg_t cfg
);

	// one setting per strobe and visible the cycle after
	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			cfg.tolerance <= mag_t'(`TOL_INIT);
			cfg.lock_lower <= mag_t'(`LOCK_LOWER_INIT);
			cfg.lock_upper <= mag_t'(`LOCK_UPPER_INIT);
			cfg.quad_tap <= tap_t'(`QUAD_TAP_INIT);
		end else if (cfg_we) begin
			case (cfg_addr)
				// dead zone half width
				2'(`CFG_ADDR_TOL): begin
					cfg.tolerance <= cfg_wdata;
				end
				// lock entry threshold
				2'(`CFG_ADDR_LOWER): begin
					cfg.lock_lower <= cfg_wdata;
				end
				// lock exit threshold
				2'(`CFG_ADDR_UPPER): begin
					cfg.lock_upper <= cfg_wdata;
				end
				// quadrature tap drops the upper data bit
				2'(`CFG_ADDR_QUAD): begin
					cfg.quad_tap <= cfg_wdata[`DELAY_W-1:0];
				end
			endcase
		end
	end

endmodule

// File: src/iq_delay_line.sv
`timescale 1ns/100ps
`include "rfo_macros.svh"

module iq_delay_line
	import rfo_pkg::*;
(
	input  logic clk10MHz_inv,
	input  logic rst,
	input  logic iq,
	input  tap_t delay_u,
	input  cfg_t cfg,
	output logic is,
	output logic is_d,
	output logic ref_drive
);

	logic iq_s;
	logic line [`LINE_LEN];
	tap_t wr_idx;
	tap_t rd_ref;
	tap_t rd_quad;
	tap_t rd_quad_d;

	// read taps count back from the write index, wrap is free
	assign rd_ref = wr_idx - delay_u;
	assign rd_quad = wr_idx - cfg.quad_tap;
	// further quarter-tap step for the sign of the phase
	assign rd_quad_d = rd_quad - tap_t'(`DELAY_W / 2);

	// free-running write pointer
	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			wr_idx <= '0;
		end else begin
			wr_idx <= wr_idx + 1'b1;
		end
	end

	// current comparator sample and line write
	always_ff @(posedge clk10MHz_inv) begin
		iq_s <= iq;
		line[wr_idx] <= iq_s;
	end

	// registered taps, total delay is tap + 2
	always_ff @(posedge clk10MHz_inv) begin
		is <= line[rd_quad];
		is_d <= line[rd_quad_d];
		// inverted to feed the relay reference
		ref_drive <= ~line[rd_ref];
	end

endmodule

// File: src/phase_detector.sv
`timescale 1ns/100ps
`include "rfo_macros.svh"

module phase_detector
	import rfo_pkg::*;
(
	input  logic clk10MHz_inv,
	input  logic rst,
	input  logic cycle,
	input  logic is,
	input  logic is_d,
	output logic cycle_s,
	output phase_meas_t meas
);

	logic cycle_m;
	logic cycle_s_d;
	logic period_start;
	logic agree;
	logic agree_d;
	mag_t agree_cnt;
	theta_t quad_cnt;

	// new period on rising command edge
	assign period_start = cycle_s & ~cycle_s_d;
	// cycle stands in for the bridge voltage
	assign agree = (cycle_s == is);
	assign agree_d = (cycle_s == is_d);

	// two-flop sync of the oscillator command
	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			cycle_m <= 1'b0;
			cycle_s <= 1'b0;
			cycle_s_d <= 1'b0;
		end else begin
			cycle_m <= cycle;
			cycle_s <= cycle_m;
			cycle_s_d <= cycle_s;
		end
	end

	// per-period counters
	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			agree_cnt <= '0;
			quad_cnt <= '0;
		end else if (period_start) begin
			// edge cycle opens the next period
			agree_cnt <= agree ? mag_t'(1) : '0;
			quad_cnt <= agree_d ? theta_t'(1) : theta_t'(-1);
		end else begin
			agree_cnt <= agree_cnt + agree;
			// up on agreement and down otherwise
			quad_cnt <= agree_d ? quad_cnt + theta_t'(1) : quad_cnt - theta_t'(1);
		end
	end

	// latch the phase with the sign of the quadrature count
	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			meas <= '0;
		end else begin
			meas.valid <= period_start;
			if (period_start) begin
				if (quad_cnt[`THETA_W-1]) begin
					meas.theta <= -theta_t'(agree_cnt);
				end else begin
					meas.theta <= theta_t'(agree_cnt);
				end
			end
		end
	end

endmodule

// File: src/phase_filter.sv
`timescale 1ns/100ps
`include "rfo_macros.svh"

module phase_filter
	import rfo_pkg::*;
(
	input  logic clk10MHz_inv,
	input  logic rst,
	input  phase_meas_t meas,
	output loop_status_t status
);

	localparam int TICK_W = $clog2(`UPDATE_DIV);

	logic [TICK_W-1:0] tick_cnt;
	logic tick_now;
	theta_t theta_f;
	theta_t theta_s;
	logic tick;
	theta_t hist [7];
	logic signed [`THETA_W:0] diff;
	logic signed [`THETA_W:0] step;
	logic signed [`THETA_W+2:0] sum;

	// error and filter step, one bit wider
	assign diff = {meas.theta[`THETA_W-1], meas.theta} - {theta_f[`THETA_W-1], theta_f};
	assign step = diff >>> `LPF_SHIFT;

	// update tick replaces the old slow clock
	assign tick_now = (tick_cnt == TICK_W'(`UPDATE_DIV - 1));

	// seven past samples plus the current one
	always_comb begin
		sum = {{3{theta_f[`THETA_W-1]}}, theta_f};
		for (int i = 0; i < 7; i++) begin
			sum = sum + {{3{hist[i][`THETA_W-1]}}, hist[i]};
		end
	end

	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			tick_cnt <= '0;
			tick <= 1'b0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			tick <= tick_now;
		end
	end

	// first-order lowpass, one step per measurement
	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			theta_f <= '0;
		end else if (meas.valid) begin
			theta_f <= theta_f + theta_t'(step);
		end
	end

	// eight-tap average on each tick
	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			theta_s <= '0;
			for (int i = 0; i < 7; i++) begin
				hist[i] <= '0;
			end
		end else if (tick_now) begin
			hist[0] <= theta_f;
			for (int i = 1; i < 7; i++) begin
				hist[i] <= hist[i-1];
			end
			// divide by 8
			theta_s <= theta_t'(sum >>> 3);
		end
	end

	// controller fills in its own tap
	assign status.theta_f = theta_f;
	assign status.theta_s = theta_s;
	assign status.delay_u = '0;
	assign status.tick = tick;

endmodule

// File: src/phase_loop_ctrl.sv
`timescale 1ns/100ps
`include "rfo_macros.svh"

module phase_loop_ctrl
	import rfo_pkg::*;
(
	input  logic clk10MHz_inv,
	input  logic rst,
	input  loop_status_t status,
	input  cfg_t cfg,
	output tap_t delay_u,
	output logic locked
);

	mag_t abs_f;
	mag_t abs_s;
	logic outside_zone;
	logic lock_next;

	// magnitude fits unsigned even for the most negative value
	function automatic mag_t mag_of(input theta_t v);
		if (v[`THETA_W-1]) begin
			return mag_t'(-v);
		end
		return mag_t'(v);
	endfunction

	assign abs_f = mag_of(status.theta_f);
	assign abs_s = mag_of(status.theta_s);
	// dead zone around zero phase
	assign outside_zone = (abs_f > cfg.tolerance);

	// hysteresis, wider window once locked
	assign lock_next = locked ? (abs_s < cfg.lock_upper) : (abs_s < cfg.lock_lower);

	// integrator on the delay tap
	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			delay_u <= tap_t'(`DELAY_U_INIT);
		end else if (status.tick && outside_zone) begin
			if (status.theta_f[`THETA_W-1]) begin
				// shorter delay, floor at 1
				delay_u <= (delay_u > tap_t'(1)) ? delay_u - 1'b1 : tap_t'(1);
			end else begin
				// longer delay, ceiling at all ones
				delay_u <= (delay_u != '1) ? delay_u + 1'b1 : '1;
			end
		end
	end

	// lock flag moves only on ticks
	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			locked <= 1'b0;
		end else if (status.tick) begin
			locked <= lock_next;
		end
	end

endmodule

// File: src/gate_driver.sv
`timescale 1ns/100ps
`include "rfo_macros.svh"

module gate_driver
	import rfo_pkg::*;
(
	input  logic clk10MHz_inv,
	input  logic rst,
	input  logic cycle_s,
	input  logic enable,
	output gates_t gates
);

	// bit 0 is leg a, bit 1 is leg b
	logic [1:0] drive;
	logic [1:0] drive_dly;
	logic [15:0][1:0] dly_line;
	logic [3:0] wr_idx;
	logic [3:0] rd_idx;

	// complementary square wave, both legs low when off
	assign drive[0] = enable & cycle_s;
	assign drive[1] = enable & ~cycle_s;

	// read DEAD_TIME entries behind, modulo 16
	assign rd_idx = wr_idx - 4'(`DEAD_TIME);
	assign drive_dly = dly_line[rd_idx];

	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			wr_idx <= '0;
			dly_line <= '0;
		end else begin
			wr_idx <= wr_idx + 1'b1;
			dly_line[wr_idx] <= drive;
		end
	end

	// p on only after drive held, n on only after drive gone
	always_ff @(posedge clk10MHz_inv) begin
		if (rst) begin
			gates.ap <= 1'b0;
			gates.an <= 1'b1;
			gates.bp <= 1'b0;
			gates.bn <= 1'b1;
		end else begin
			gates.ap <= drive[0] & drive_dly[0];
			gates.an <= ~(drive[0] | drive_dly[0]);
			gates.bp <= drive[1] & drive_dly[1];
			gates.bn <= ~(drive[1] | drive_dly[1]);
		end
	end

endmodule

// File: src/rfo_phase_lock.sv
`timescale 1ns/100ps
`include "rfo_macros.svh"

module rfo_phase_lock
	import rfo_pkg::*;
(
	input  logic clk10MHz_inv,
	input  logic rst,
	input  logic cycle,
	input  logic iq,
	input  logic enable,
	input  logic cfg_we,
	input  logic [1:0] cfg_addr,
	input  logic [`THETA_W-1:0] cfg_wdata,
	output gates_t gates,
	output logic ref_drive,
	output logic locked,
	output loop_status_t status_out
);

	cfg_t cfg;
	tap_t delay_u;
	logic is;
	logic is_d;
	logic cycle_s;
	phase_meas_t meas;
	loop_status_t flt_status;

	// tolerance, lock thresholds, quadrature tap
	loop_regs regs_i (
		.clk10MHz_inv (clk10MHz_inv),
		.rst (rst),
		.cfg_we (cfg_we),
		.cfg_addr (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg (cfg)
	);

	// current sign history and taps
	iq_delay_line dly_i (
		.clk10MHz_inv (clk10MHz_inv),
		.rst (rst),
		.iq (iq),
		.delay_u (delay_u),
		.cfg (cfg),
		.is (is),
		.is_d (is_d),
		.ref_drive (ref_drive)
	);

	phase_detector det_i (
		.clk10MHz_inv (clk10MHz_inv),
		.rst (rst),
		.cycle (cycle),
		.is (is),
		.is_d (is_d),
		.cycle_s (cycle_s),
		.meas (meas)
	);

	phase_filter flt_i (
		.clk10MHz_inv (clk10MHz_inv),
		.rst (rst),
		.meas (meas),
		.status (flt_status)
	);

	// tap integrator and lock flag
	phase_loop_ctrl ctrl_i (
		.clk10MHz_inv (clk10MHz_inv),
		.rst (rst),
		.status (flt_status),
		.cfg (cfg),
		.delay_u (delay_u),
		.locked (locked)
	);

	gate_driver gate_i (
		.clk10MHz_inv (clk10MHz_inv),
		.rst (rst),
		.cycle_s (cycle_s),
		.enable (enable),
		.gates (gates)
	);

	// filter status with the live tap merged in
	assign status_out.theta_f = flt_status.theta_f;
	assign status_out.theta_s = flt_status.theta_s;
	assign status_out.delay_u = delay_u;
	assign status_out.tick = flt_status.tick;

endmodule

// File: tests/rfo_asserts.sv
`timescale 1ns/100ps

module rfo_asserts
	import rfo_pkg::*;
(
	input  logic clk10MHz_inv,
	input  logic rst,
	input  gates_t gates,
	input  logic locked,
	input  loop_status_t status_out
);

	int fail_cnt = 0;

	// high and low side of one leg never on together nor back to back
	no_shoot_through: assert property (@(posedge clk10MHz_inv) disable iff (rst)
		!(gates.ap && gates.an) && !(gates.bp && gates.bn) &&
		!(gates.ap && $past(gates.an)) && !(gates.an && $past(gates.ap)) &&
		!(gates.bp && $past(gates.bn)) && !(gates.bn && $past(gates.bp)))
	else begin
		fail_cnt++;
		$error("high and low side of one bridge leg on together or without a gap");
	end

	// integrator moves one tap at most, no wrap allowed
	delay_single_step: assert property (@(posedge clk10MHz_inv) disable iff (rst)
		(int'(status_out.delay_u) <= int'($past(status_out.delay_u)) + 1) &&
		(int'(status_out.delay_u) + 1 >= int'($past(status_out.delay_u))))
	else begin
		fail_cnt++;
		$error("delay_u stepped by more than one tap");
	end

	// lock flag only follows a tick
	lock_on_tick: assert property (@(posedge clk10MHz_inv) disable iff (rst)
		(locked != $past(locked)) |-> $past(status_out.tick))
	else begin
		fail_cnt++;
		$error("locked changed without a preceding tick");
	end

endmodule

// File: tests/rfo_checker.sv
`timescale 1ns/100ps
`include "rfo_macros.svh"

module rfo_checker
	import rfo_pkg::*;
(
	input  logic clk10MHz_inv,
	input  logic rst,
	input  logic cycle,
	input  logic iq,
	input  logic enable,
	input  logic cfg_we,
	input  logic [1:0] cfg_addr,
	input  logic [`THETA_W-1:0] cfg_wdata,
	input  gates_t gates,
	input  logic ref_drive,
	input  logic locked,
	input  loop_status_t status_out,
	output int err_cnt,
	output int chk_cnt
);

	int n = 0;
	int en_low = 0;
	int last_tick = -1;
	int m_tcnt;
	logic iq_hist [512];
	logic [1:0] drv_hist [32];
	cfg_t m_cfg;
	logic m_cm, m_cs, m_csd, m_is, m_isd, m_ref, m_valid, m_tick, m_locked;
	logic [`THETA_W-1:0] m_agree;
	theta_t m_quad, m_theta, m_tf, m_ts;
	theta_t m_hist [7];
	tap_t m_du;
	gates_t m_gates;

	initial begin
		err_cnt = 0;
		chk_cnt = 0;
		for (int i = 0; i < 512; i++) begin
			iq_hist[i] = 1'b0;
		end
		for (int i = 0; i < 32; i++) begin
			drv_hist[i] = 2'b00;
		end
	end

	// sampled current k edges into the run, quiet before time zero
	function automatic logic iq_at(input int k);
		return (k < 0) ? 1'b0 : iq_hist[k % 512];
	endfunction

	function automatic int mag(input theta_t v);
		return (v < 0) ? -int'(v) : int'(v);
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
		chk_cnt++;
		if (exp !== got) begin
			err_cnt++;
			$display("CHECK FAILED %s expected %h got %h", name, exp, got);
		end
	endtask

	always @(posedge clk10MHz_inv) begin : model
		int sum;
		int d;
		logic ps, ag, ag_d, is_n, isd_n, ref_n;
		logic [1:0] drv;
		logic [1:0] drv_d;
		// ports hold what the last edge produced
		if (n > 20) begin
			compare("theta_f", m_tf, status_out.theta_f);
			compare("theta_s", m_ts, status_out.theta_s);
			compare("delay_u", m_du, status_out.delay_u);
			compare("tick", m_tick, status_out.tick);
			compare("locked", m_locked, locked);
			compare("ref_drive", m_ref, ref_drive);
			compare("gates", m_gates, gates);
			if (en_low > `DEAD_TIME + 3 && gates !== 4'b0101) begin
				err_cnt++;
				$display("gates did not reach the off state after enable dropped");
			end
			if (status_out.tick) begin
				if (last_tick >= 0 && n - last_tick != `UPDATE_DIV) begin
					err_cnt++;
					$display("ticks came %0d cycles apart instead of %0d", n - last_tick,
						`UPDATE_DIV);
				end
				last_tick = n;
			end
		end
		en_low = enable ? 0 : en_low + 1;
		// taps read with the settings in force before this edge
		is_n = iq_at(n - int'(m_cfg.quad_tap) - 1);
		isd_n = iq_at(n - int'(m_cfg.quad_tap) - 1 - `DELAY_W / 2);
		ref_n = ~iq_at(n - int'(m_du) - 1);
		ps = m_cs & ~m_csd;
		ag = (m_cs == m_is);
		ag_d = (m_cs == m_isd);
		drv = {enable & ~m_cs, enable & m_cs};
		drv_d = (n >= `DEAD_TIME) ? drv_hist[(n - `DEAD_TIME) % 32] : 2'b00;
		drv_hist[n % 32] = rst ? 2'b00 : drv;
		if (rst) begin
			m_du = tap_t'(`DELAY_U_INIT);
			m_locked = 1'b0;
			m_tcnt = 0;
			m_tick = 1'b0;
			m_tf = '0;
			m_ts = '0;
			for (int i = 0; i < 7; i++) begin
				m_hist[i] = '0;
			end
			{m_cm, m_cs, m_csd, m_valid} = 4'b0000;
			m_agree = '0;
			m_quad = '0;
			m_theta = '0;
			m_gates = 4'b0101;
		end else begin
			// loop control on the tick of the last edge
			if (m_tick) begin
				if (mag(m_tf) > int'(m_cfg.tolerance)) begin
					if (m_tf < 0) begin
						m_du = (m_du > 1) ? m_du - 1 : tap_t'(1);
					end else begin
						m_du = (m_du < 255) ? m_du + 1 : tap_t'(255);
					end
				end
				m_locked = m_locked ? (mag(m_ts) < int'(m_cfg.lock_upper)) :
					(mag(m_ts) < int'(m_cfg.lock_lower));
			end
			// average of theta_f and seven older samples
			if (m_tcnt == `UPDATE_DIV - 1) begin
				sum = int'(m_tf);
				for (int i = 0; i < 7; i++) begin
					sum += int'(m_hist[i]);
				end
				m_ts = theta_t'(sum >>> 3);
				for (int i = 6; i > 0; i--) begin
					m_hist[i] = m_hist[i-1];
				end
				m_hist[0] = m_tf;
			end
			m_tick = (m_tcnt == `UPDATE_DIV - 1);
			m_tcnt = (m_tcnt + 1) % `UPDATE_DIV;
			if (m_valid) begin
				d = int'(m_theta) - int'(m_tf);
				m_tf = theta_t'(int'(m_tf) + (d >>> `LPF_SHIFT));
			end
			// period counts, signed by the quadrature sum
			m_valid = ps;
			if (ps) begin
				m_theta = m_quad[`THETA_W-1] ? theta_t'(-int'(m_agree)) : theta_t'(m_agree);
				m_agree = ag ? 1 : 0;
				m_quad = ag_d ? theta_t'(1) : theta_t'(-1);
			end else begin
				m_agree = m_agree + ag;
				m_quad = ag_d ? m_quad + 1 : m_quad - 1;
			end
			{m_csd, m_cs, m_cm} = {m_cs, m_cm, cycle};
			m_gates = {drv[0] & drv_d[0], ~(drv[0] | drv_d[0]),
				drv[1] & drv_d[1], ~(drv[1] | drv_d[1])};
		end
		m_is = is_n;
		m_isd = isd_n;
		m_ref = ref_n;
		iq_hist[n % 512] = iq;
		// register copy takes a write at this edge
		if (rst) begin
			m_cfg = {mag_t'(`TOL_INIT), mag_t'(`LOCK_LOWER_INIT), mag_t'(`LOCK_UPPER_INIT),
				tap_t'(`QUAD_TAP_INIT)};
		end else if (cfg_we) begin
			case (cfg_addr)
				2'd0: m_cfg.tolerance = cfg_wdata;
				2'd1: m_cfg.lock_lower = cfg_wdata;
				2'd2: m_cfg.lock_upper = cfg_wdata;
				default: m_cfg.quad_tap = cfg_wdata[7:0];
			endcase
		end
		n++;
	end

endmodule

// File: tests/tb_rfo_phase_lock.sv
`timescale 1ns/100ps
`include "rfo_macros.svh"

module tb_rfo_phase_lock
	import rfo_pkg::*;
();

	localparam int RESET_CYCLES = 16;
	localparam int WARMUP_CYCLES = 300;
	localparam int SECTION_CYCLES = 4000;
	// whole run plus a quarter of margin
	localparam int TIMEOUT_CYCLES = (RESET_CYCLES + WARMUP_CYCLES + 4 * SECTION_CYCLES) * 5 / 4;

	logic clk10MHz_inv, rst, cycle, iq, enable, cfg_we;
	logic [1:0] cfg_addr;
	logic [`THETA_W-1:0] cfg_wdata;
	gates_t gates;
	logic ref_drive, locked;
	loop_status_t status_out;
	int err_cnt, chk_cnt, assert_cnt;
	int seed;
	int cyc_cnt = 0;
	// oscillator model state
	int period, pos, offset;
	logic [255:0] cyc_line;

	rfo_phase_lock dut_i (.*);

	rfo_checker checker_i (.*);

	bind rfo_phase_lock rfo_asserts asserts_i (
		.clk10MHz_inv (clk10MHz_inv), .rst (rst), .gates (gates),
		.locked (locked), .status_out (status_out));

	initial begin
		clk10MHz_inv = 1'b0;
		forever #50 clk10MHz_inv = ~clk10MHz_inv;
	end

	function automatic int rand_below(input int lim);
		return int'($unsigned($random(seed)) % lim);
	endfunction

	// square wave of random period with iq lagging by offset and rarely flipped
	task automatic step_osc;
		logic c;
		pos++;
		if (pos >= period) begin
			pos = 0;
			period = 120 + rand_below(101);
		end
		c = (pos < period / 2);
		cyc_line = {cyc_line[254:0], c};
		cycle <= c;
		iq <= cyc_line[offset] ^ (rand_below(64) == 0);
	endtask

	task automatic write_random_cfg;
		logic [1:0] a;
		a = 2'(rand_below(4));
		cfg_we <= 1'b1;
		cfg_addr <= a;
		case (a)
			2'd0: cfg_wdata <= 9'(rand_below(16));
			2'd1: cfg_wdata <= 9'(5 + rand_below(36));
			2'd2: cfg_wdata <= 9'(20 + rand_below(61));
			// bit 8 set now and then and dropped by the register
			default: cfg_wdata <= {1'(rand_below(2)), 8'(20 + rand_below(41))};
		endcase
	endtask

	task automatic run_section(input int count, input bit cfg_on, input bit en_toggle);
		repeat (count) begin
			@(posedge clk10MHz_inv);
			step_osc();
			if (cfg_on && rand_below(200) == 0) begin
				write_random_cfg();
			end else begin
				cfg_we <= 1'b0;
			end
			if (en_toggle && rand_below(500) == 0) begin
				enable <= ~enable;
			end
		end
	endtask

	always @(posedge clk10MHz_inv) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		seed = 32'he53a;
		{rst, cycle, iq, enable, cfg_we} = 5'b10000;
		cfg_addr = '0;
		cfg_wdata = '0;
		period = 160;
		pos = 0;
		offset = 0;
		cyc_line = '0;
		repeat (RESET_CYCLES) @(posedge clk10MHz_inv);
		rst <= 1'b0;
		// fill the delay line with a quiet current
		repeat (WARMUP_CYCLES) @(posedge clk10MHz_inv);
		enable <= 1'b1;
		offset = 10 + rand_below(60);
		run_section(SECTION_CYCLES, 1'b0, 1'b0);
		offset = rand_below(200);
		run_section(SECTION_CYCLES, 1'b1, 1'b0);
		run_section(SECTION_CYCLES, 1'b0, 1'b1);
		offset = rand_below(200);
		run_section(SECTION_CYCLES, 1'b1, 1'b1);
		repeat (4) @(posedge clk10MHz_inv);
		assert_cnt = dut_i.asserts_i.fail_cnt;
		$display("errors %0d, assertion failures %0d, checks %0d", err_cnt, assert_cnt, chk_cnt);
		if (err_cnt == 0 && assert_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: rfo_phase_lock.f
+incdir+src
src/rfo_pkg.sv
src/loop_regs.sv
src/iq_delay_line.sv
src/phase_detector.sv
src/phase_filter.sv
src/phase_loop_ctrl.sv
src/gate_driver.sv
src/rfo_phase_lock.sv
tests/rfo_asserts.sv
tests/rfo_checker.sv
tests/tb_rfo_phase_lock.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, pass only if the log holds the pass message
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f rfo_phase_lock.f \
	--top-module tb_rfo_phase_lock -o sim_tb > sim.log 2>&1 \
	&& ./obj_dir/sim_tb >> sim.log 2>&1
grep -q "^Finished with no errors$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
